// ==== include/decode_consts.svh ====
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Register file and datapath
`define DATA_W 32
`define REG_COUNT 32
`define REG_IDX_W 5

// Instruction field widths
`define OPCODE_W 6
`define FUNCT_W 6
`define IMM16_W 16
`define TARGET_W 26

`endif

// ==== verilog/isa_pkg.sv ====
`include "decode_consts.svh"

package isa_pkg;

	typedef enum logic [`OPCODE_W-1:0] {
		OPC_RTYPE = 6'b000000,
		OPC_REGIMM = 6'b000001,
		OPC_J = 6'b000010,
		OPC_JAL = 6'b000011,
		OPC_BEQ = 6'b000100,
		OPC_BNE = 6'b000101,
		OPC_BLEZ = 6'b000110,
		OPC_BGTZ = 6'b000111,
		OPC_ADDI = 6'b001000,
		OPC_ADDIU = 6'b001001,
		OPC_SLTI = 6'b001010,
		OPC_SLTIU = 6'b001011,
		OPC_ORI = 6'b001101,
		OPC_XORI = 6'b001110,
		OPC_LUI = 6'b001111,
		OPC_MUL = 6'b011100, // Special opcode, only funct MUL
		OPC_LB = 6'b100000,
		OPC_LW = 6'b100011,
		OPC_LBU = 6'b100100,
		OPC_SB = 6'b101000,
		OPC_SW = 6'b101011
	} opcode_e;

	typedef enum logic [`FUNCT_W-1:0] {
		FN_SLL = 6'b000000,
		FN_SRL = 6'b000010,
		FN_SRA = 6'b000011,
		FN_SLLV = 6'b000100,
		FN_SRLV = 6'b000110,
		FN_SRAV = 6'b000111,
		FN_JR = 6'b001000,
		FN_JALR = 6'b001001,
		FN_MFHI = 6'b010000,
		FN_MFLO = 6'b010010,
		FN_MULT = 6'b011000,
		FN_MULTU = 6'b011001,
		FN_DIV = 6'b011010,
		FN_DIVU = 6'b011011,
		FN_ADD = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND = 6'b100100,
		FN_OR = 6'b100101,
		FN_XOR = 6'b100110,
		FN_NOR = 6'b100111,
		FN_SLT = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	// MUL reuses the SRL code, told apart by its opcode
	localparam funct_e FN_MUL = FN_SRL;

	typedef enum logic [`REG_IDX_W-1:0] {
		RI_BLTZ = 5'b00000,
		RI_BGEZ = 5'b00001
	} regimm_e;

	typedef struct packed {
		opcode_e opcode;
		logic [`REG_IDX_W-1:0] rs;
		logic [`REG_IDX_W-1:0] rt;
		logic [`REG_IDX_W-1:0] rd;
		logic [`REG_IDX_W-1:0] shamt;
		funct_e funct;
	} insn_t;

endpackage

// ==== verilog/decode_pkg.sv ====
`include "decode_consts.svh"

package decode_pkg;

	typedef enum logic [5:0] {
		OP_NOP = 6'd0, OP_ADD = 6'd1, OP_ADDU = 6'd2, OP_SUB = 6'd3,
		OP_SUBU = 6'd4, OP_MULT = 6'd5, OP_MULTU = 6'd6, OP_DIV = 6'd7,
		OP_DIVU = 6'd8, OP_MFHI = 6'd9, OP_MFLO = 6'd10, OP_SLT = 6'd11,
		OP_SLTU = 6'd12, OP_SLL = 6'd13, OP_SLLV = 6'd14, OP_SRL = 6'd15,
		OP_SRLV = 6'd16, OP_SRA = 6'd17, OP_SRAV = 6'd18, OP_AND = 6'd19,
		OP_OR = 6'd20, OP_XOR = 6'd21, OP_NOR = 6'd22, OP_JALR = 6'd23,
		OP_JR = 6'd24, OP_MUL = 6'd25,
		OP_ADDI = 6'd26, OP_ADDIU = 6'd27, OP_SLTI = 6'd28, OP_SLTIU = 6'd29,
		OP_ORI = 6'd30, OP_XORI = 6'd31, OP_LW = 6'd32, OP_SW = 6'd33,
		OP_LB = 6'd34, OP_LBU = 6'd35, OP_SB = 6'd36, OP_LUI = 6'd37,
		OP_BEQ = 6'd38, OP_BNE = 6'd39, OP_BGTZ = 6'd40, OP_BLEZ = 6'd41,
		OP_BLTZ = 6'd42, OP_BGEZ = 6'd43,
		OP_J = 6'd44, OP_JAL = 6'd45,
		OP_ILLEGAL = 6'd63
	} alu_op_e;

	typedef struct packed {
		logic [`DATA_W-1:0] pc;
		isa_pkg::insn_t insn;
	} fetch_t;

	typedef struct packed {
		logic we;
		logic [`REG_IDX_W-1:0] addr;
		logic [`DATA_W-1:0] data;
	} wb_t;

	typedef struct packed {
		logic [`OPCODE_W-1:0] opcode;
		logic [`REG_IDX_W-1:0] rs;
		logic [`REG_IDX_W-1:0] rt;
		logic [`REG_IDX_W-1:0] rd;
		logic [`REG_IDX_W-1:0] shamt;
		logic [`FUNCT_W-1:0] funct;
		alu_op_e op;
		logic [`DATA_W-1:0] imm_ext; // Sign or zero extended
		logic [`DATA_W-1:0] pc;
		logic [`DATA_W-1:0] insn;
	} decoded_t;

endpackage

// ==== verilog/insn_decoder.sv ====
`include "decode_consts.svh"

module insn_decoder (
	input decode_pkg::fetch_t fetch,
	output decode_pkg::decoded_t decoded
);

	isa_pkg::insn_t insn;
	logic [`DATA_W-1:0] word;
	logic itype;
	logic illegal;
	decode_pkg::decoded_t dec;

	assign insn = fetch.insn;
	assign word = fetch.insn;

	always_comb begin
		dec = '0;
		itype = 1'b0;
		illegal = 1'b0;
		case (insn.opcode)
			isa_pkg::OPC_RTYPE: begin
				dec.rs = insn.rs;
				dec.rt = insn.rt;
				dec.rd = insn.rd;
				dec.funct = insn.funct;
				case (insn.funct)
					isa_pkg::FN_ADD: dec.op = decode_pkg::OP_ADD;
					isa_pkg::FN_ADDU: dec.op = decode_pkg::OP_ADDU;
					isa_pkg::FN_SUB: dec.op = decode_pkg::OP_SUB;
					isa_pkg::FN_SUBU: dec.op = decode_pkg::OP_SUBU;
					isa_pkg::FN_SLT: dec.op = decode_pkg::OP_SLT;
					isa_pkg::FN_SLTU: dec.op = decode_pkg::OP_SLTU;
					isa_pkg::FN_SLLV: dec.op = decode_pkg::OP_SLLV;
					isa_pkg::FN_SRLV: dec.op = decode_pkg::OP_SRLV;
					isa_pkg::FN_SRAV: dec.op = decode_pkg::OP_SRAV;
					isa_pkg::FN_AND: dec.op = decode_pkg::OP_AND;
					isa_pkg::FN_OR: dec.op = decode_pkg::OP_OR;
					isa_pkg::FN_XOR: dec.op = decode_pkg::OP_XOR;
					isa_pkg::FN_NOR: dec.op = decode_pkg::OP_NOR;
					isa_pkg::FN_JALR: dec.op = decode_pkg::OP_JALR;
					isa_pkg::FN_MULT: begin
						dec.op = decode_pkg::OP_MULT;
						dec.rd = '0; // Result goes to HI/LO
					end
					isa_pkg::FN_MULTU: begin
						dec.op = decode_pkg::OP_MULTU;
						dec.rd = '0;
					end
					isa_pkg::FN_DIV: begin
						dec.op = decode_pkg::OP_DIV;
						dec.rd = '0;
					end
					isa_pkg::FN_DIVU: begin
						dec.op = decode_pkg::OP_DIVU;
						dec.rd = '0;
					end
					isa_pkg::FN_MFHI: begin
						dec.op = decode_pkg::OP_MFHI;
						dec.rs = '0;
						dec.rt = '0;
					end
					isa_pkg::FN_MFLO: begin
						dec.op = decode_pkg::OP_MFLO;
						dec.rs = '0;
						dec.rt = '0;
					end
					isa_pkg::FN_SLL: begin
						dec.op = decode_pkg::OP_SLL;
						dec.rs = '0;
						dec.shamt = insn.shamt; // Constant shift
					end
					isa_pkg::FN_SRL: begin
						dec.op = decode_pkg::OP_SRL;
						dec.rs = '0;
						dec.shamt = insn.shamt;
					end
					isa_pkg::FN_SRA: begin
						dec.op = decode_pkg::OP_SRA;
						dec.rs = '0;
						dec.shamt = insn.shamt;
					end
					isa_pkg::FN_JR: begin
						dec.op = decode_pkg::OP_JR;
						dec.rt = '0;
						dec.rd = '0;
					end
					default: illegal = 1'b1;
				endcase
			end
			isa_pkg::OPC_MUL: begin
				if (insn.funct == isa_pkg::FN_MUL) begin
					dec.opcode = insn.opcode;
					dec.rs = insn.rs;
					dec.rt = insn.rt;
					dec.rd = insn.rd;
					dec.funct = insn.funct;
					dec.op = decode_pkg::OP_MUL;
				end else begin
					illegal = 1'b1;
				end
			end
			isa_pkg::OPC_ADDI: dec.op = decode_pkg::OP_ADDI;
			isa_pkg::OPC_ADDIU: dec.op = decode_pkg::OP_ADDIU;
			isa_pkg::OPC_SLTI: dec.op = decode_pkg::OP_SLTI;
			isa_pkg::OPC_SLTIU: dec.op = decode_pkg::OP_SLTIU;
			isa_pkg::OPC_ORI: dec.op = decode_pkg::OP_ORI;
			isa_pkg::OPC_XORI: dec.op = decode_pkg::OP_XORI;
			isa_pkg::OPC_LW: dec.op = decode_pkg::OP_LW;
			isa_pkg::OPC_SW: dec.op = decode_pkg::OP_SW;
			isa_pkg::OPC_LB: dec.op = decode_pkg::OP_LB;
			isa_pkg::OPC_LBU: dec.op = decode_pkg::OP_LBU;
			isa_pkg::OPC_SB: dec.op = decode_pkg::OP_SB;
			isa_pkg::OPC_LUI: dec.op = decode_pkg::OP_LUI;
			isa_pkg::OPC_BEQ: dec.op = decode_pkg::OP_BEQ;
			isa_pkg::OPC_BNE: dec.op = decode_pkg::OP_BNE;
			isa_pkg::OPC_BGTZ: dec.op = decode_pkg::OP_BGTZ;
			isa_pkg::OPC_BLEZ: dec.op = decode_pkg::OP_BLEZ;
			isa_pkg::OPC_REGIMM: begin
				dec.opcode = insn.opcode;
				dec.rs = insn.rs;
				dec.rt = insn.rt;
				dec.imm_ext = {{(`DATA_W - `IMM16_W){word[`IMM16_W-1]}}, word[`IMM16_W-1:0]};
				case (insn.rt) // Condition lives in rt
					isa_pkg::RI_BLTZ: dec.op = decode_pkg::OP_BLTZ;
					isa_pkg::RI_BGEZ: dec.op = decode_pkg::OP_BGEZ;
					default: illegal = 1'b1;
				endcase
			end
			isa_pkg::OPC_J,
			isa_pkg::OPC_JAL: begin
				dec.opcode = insn.opcode;
				dec.op = (insn.opcode == isa_pkg::OPC_J) ? decode_pkg::OP_J : decode_pkg::OP_JAL;
				dec.imm_ext = {{(`DATA_W - `TARGET_W){1'b0}}, word[`TARGET_W-1:0]};
			end
			default: illegal = 1'b1;
		endcase

		// Every opcode not matched above is I-type
		itype = !illegal && dec.op >= decode_pkg::OP_ADDI && dec.op <= decode_pkg::OP_BLEZ;
		if (itype) begin
			dec.opcode = insn.opcode;
			dec.rs = (insn.opcode == isa_pkg::OPC_LUI) ? '0 : insn.rs;
			dec.rt = insn.rt;
			dec.rd = insn.rt; // Destination is rt
			dec.imm_ext = {{(`DATA_W - `IMM16_W){word[`IMM16_W-1]}}, word[`IMM16_W-1:0]};
		end

		if (word == '0) begin
			dec.op = decode_pkg::OP_NOP; // Would otherwise read as SLL r0
		end
		if (illegal) begin
			dec = '0;
			dec.op = decode_pkg::OP_ILLEGAL;
		end
		dec.pc = fetch.pc;
		dec.insn = word;
	end

	assign decoded = dec;

endmodule

// ==== verilog/reg_file.sv ====
`include "decode_consts.svh"

module reg_file (
	input logic clock,
	input logic arst_n,
	input logic [`REG_IDX_W-1:0] rs_addr,
	input logic [`REG_IDX_W-1:0] rt_addr,
	input decode_pkg::wb_t wb,
	output logic [`DATA_W-1:0] rs_data,
	output logic [`DATA_W-1:0] rt_data
);

	logic [`DATA_W-1:0] regs [`REG_COUNT];

	// Reset loads each register with its own index
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= `DATA_W'(i);
			end
		end else if (wb.we) begin
			regs[wb.addr] <= wb.data; // r0 is writable too
		end
	end

	// No bypass, a write shows after the edge
	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

	wb_addr_known: assert property (
		@(posedge clock) disable iff (!arst_n)
		wb.we |-> !$isunknown(wb.addr)
	);

endmodule

// ==== verilog/decode_stage.sv ====
`include "decode_consts.svh"

module decode_stage (
	input logic clock,
	input logic arst_n,
	input logic decode_en,
	input decode_pkg::fetch_t fetch,
	input decode_pkg::wb_t wb,
	output decode_pkg::decoded_t decoded,
	output logic decode_valid,
	output logic [`DATA_W-1:0] rs_data,
	output logic [`DATA_W-1:0] rt_data
);

	decode_pkg::decoded_t decoded_next;

	insn_decoder decoder_i (
		.fetch(fetch),
		.decoded(decoded_next)
	);

	// Bundle holds while decode is disabled
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			decoded <= '0; // Reads as a NOP
			decode_valid <= 1'b0;
		end else begin
			decode_valid <= decode_en;
			if (decode_en) begin
				decoded <= decoded_next;
			end
		end
	end

	// Operands read from the registered indices
	reg_file reg_file_i (
		.clock(clock),
		.arst_n(arst_n),
		.rs_addr(decoded.rs),
		.rt_addr(decoded.rt),
		.wb(wb),
		.rs_data(rs_data),
		.rt_data(rt_data)
	);

	op_known_when_valid: assert property (
		@(posedge clock) disable iff (!arst_n)
		decode_valid |-> !$isunknown(decoded.op)
	);

	valid_low_after_reset: assert property (
		@(posedge clock)
		$rose(arst_n) |-> !decode_valid
	);

endmodule

// ==== dv/decode_stage_tb.sv ====
`include "decode_consts.svh"

module decode_stage_tb;

	localparam int CHECK_W = $bits(decode_pkg::decoded_t);
	localparam int VALID_TIMEOUT = 20; // Cycles to wait for decode_valid

	logic clock;
	logic arst_n;
	logic decode_en;
	decode_pkg::fetch_t fetch;
	decode_pkg::wb_t wb;
	decode_pkg::decoded_t decoded;
	logic decode_valid;
	logic [`DATA_W-1:0] rs_data;
	logic [`DATA_W-1:0] rt_data;

	int errors;
	int checks;
	logic [`DATA_W-1:0] last_pc; // Last accepted instruction
	logic [`DATA_W-1:0] last_insn;
	logic [5:0] last_op;

	decode_stage dut_i (
		.clock(clock),
		.arst_n(arst_n),
		.decode_en(decode_en),
		.fetch(fetch),
		.wb(wb),
		.decoded(decoded),
		.decode_valid(decode_valid),
		.rs_data(rs_data),
		.rt_data(rt_data)
	);

	always #5 clock = ~clock;

	task automatic check_value(input string name, input logic [CHECK_W-1:0] got,
		input logic [CHECK_W-1:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("FAIL %s: got %0h, expected %0h", name, got, expected);
		end
	endtask

	task automatic run_write(input string line);
		logic [`REG_IDX_W-1:0] addr;
		logic [`DATA_W-1:0] data;
		int n;
		n = $sscanf(line, "W %h %h", addr, data);
		if (n != 2) begin
			$display("malformed write line in test file: %s", line);
			errors++;
			return;
		end
		@(posedge clock);
		wb.we <= 1'b1;
		wb.addr <= addr;
		wb.data <= data;
		@(posedge clock); // Write lands on this edge
		wb.we <= 1'b0;
	endtask

	task automatic run_decode(input string line);
		logic [`DATA_W-1:0] pc;
		logic [`DATA_W-1:0] insn;
		logic [`DATA_W-1:0] op;
		logic [`DATA_W-1:0] opcode;
		logic [`DATA_W-1:0] rs;
		logic [`DATA_W-1:0] rt;
		logic [`DATA_W-1:0] rd;
		logic [`DATA_W-1:0] shamt;
		logic [`DATA_W-1:0] funct;
		logic [`DATA_W-1:0] imm;
		logic [`DATA_W-1:0] rs_val;
		logic [`DATA_W-1:0] rt_val;
		isa_pkg::insn_t word;
		int n;
		int waited;
		int errors_before;
		n = $sscanf(line, "D %h %h %h %h %h %h %h %h %h %h %h %h", pc, insn, op, opcode,
			rs, rt, rd, shamt, funct, imm, rs_val, rt_val);
		if (n != 12) begin
			$display("malformed decode line in test file: %s", line);
			errors++;
			return;
		end
		word = insn;
		@(posedge clock);
		fetch <= {pc, insn};
		decode_en <= 1'b1;
		@(posedge clock); // Acceptance edge
		decode_en <= 1'b0;
		waited = 0;
		@(negedge clock);
		while (!decode_valid && waited < VALID_TIMEOUT) begin
			@(negedge clock);
			waited++;
		end
		if (!decode_valid) begin
			$display("timeout: decode_valid never rose for the instruction at pc %h", pc);
			errors++;
			return;
		end
		if (waited != 0) begin
			$display("decode_valid rose %0d cycles late for the instruction at pc %h",
				waited, pc);
			errors++;
		end
		errors_before = errors;
		check_value("decoded.op", CHECK_W'(decoded.op), CHECK_W'(op));
		check_value("decoded.opcode", CHECK_W'(decoded.opcode), CHECK_W'(opcode));
		check_value("decoded.rs", CHECK_W'(decoded.rs), CHECK_W'(rs));
		check_value("decoded.rt", CHECK_W'(decoded.rt), CHECK_W'(rt));
		check_value("decoded.rd", CHECK_W'(decoded.rd), CHECK_W'(rd));
		check_value("decoded.shamt", CHECK_W'(decoded.shamt), CHECK_W'(shamt));
		check_value("decoded.funct", CHECK_W'(decoded.funct), CHECK_W'(funct));
		check_value("decoded.imm_ext", CHECK_W'(decoded.imm_ext), CHECK_W'(imm));
		check_value("decoded.pc", CHECK_W'(decoded.pc), CHECK_W'(pc));
		check_value("decoded.insn", CHECK_W'(decoded.insn), CHECK_W'(insn));
		check_value("rs_data", CHECK_W'(rs_data), CHECK_W'(rs_val));
		check_value("rt_data", CHECK_W'(rt_data), CHECK_W'(rt_val));
		if (errors != errors_before) begin
			$display("  while decoding pc %h, insn %h (opcode %0h, funct %0h)", pc, insn,
				word.opcode, word.funct);
		end
		last_pc = pc;
		last_insn = insn;
		last_op = op[5:0];
	endtask

	task automatic run_stall(input string line);
		int cycles;
		int n;
		n = $sscanf(line, "S %d", cycles);
		if (n != 1) begin
			$display("malformed stall line in test file: %s", line);
			errors++;
			return;
		end
		repeat (cycles) begin
			@(posedge clock);
			@(negedge clock);
			check_value("decode_valid", CHECK_W'(decode_valid), '0);
			check_value("decoded.pc", CHECK_W'(decoded.pc), CHECK_W'(last_pc));
			check_value("decoded.insn", CHECK_W'(decoded.insn), CHECK_W'(last_insn));
			check_value("decoded.op", CHECK_W'(decoded.op), CHECK_W'(last_op));
		end
	endtask

	initial begin
		int fd;
		string line;
		logic [7:0] kind;
		clock = 1'b0;
		arst_n = 1'b0;
		decode_en = 1'b0;
		fetch = '0;
		wb = '0;
		errors = 0;
		checks = 0;
		last_pc = '0;
		last_insn = '0;
		last_op = '0;

		repeat (8) @(posedge clock);
		arst_n <= 1'b1;
		@(negedge clock);
		check_value("decode_valid", CHECK_W'(decode_valid), '0);
		check_value("decoded", CHECK_W'(decoded), '0); // Reset bundle is a NOP

		fd = $fopen("dv/decode_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open the test vector file dv/decode_tests.txt");
			errors++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 0) begin
					kind = line.getc(0);
					case (kind)
						"W": run_write(line);
						"D": run_decode(line);
						"S": run_stall(line);
						"#", "\n", "\r", " ": begin
						end
						default: begin
							$display("unknown command in test file: %s", line);
							errors++;
						end
					endcase
				end
			end
			$fclose(fd);
		end

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== dv/decode_tests.txt ====
# W addr data | S cycles (decimal)
# D pc insn op opcode rs rt rd shamt funct imm_ext rs_data rt_data, all hex
D 00400000 00a71820 01 00 05 07 03 00 20 00000000 00000005 00000007 # add r3,r5,r7
D 00400004 00222021 02 00 01 02 04 00 21 00000000 00000001 00000002 # addu
D 00400008 01095022 03 00 08 09 0a 00 22 00000000 00000008 00000009 # sub
D 0040000c 016c6823 04 00 0b 0c 0d 00 23 00000000 0000000b 0000000c # subu
D 00400010 01cf80e4 13 00 0e 0f 10 00 24 00000000 0000000e 0000000f # and, stray shamt bits
D 00400014 02329825 14 00 11 12 13 00 25 00000000 00000011 00000012 # or
D 00400018 0295b026 15 00 14 15 16 00 26 00000000 00000014 00000015 # xor
D 0040001c 02f8c827 16 00 17 18 19 00 27 00000000 00000017 00000018 # nor
D 00400020 035be02a 0b 00 1a 1b 1c 00 2a 00000000 0000001a 0000001b # slt
D 00400024 03bef82b 0c 00 1d 1e 1f 00 2b 00000000 0000001d 0000001e # sltu
D 00400028 00642804 0e 00 03 04 05 00 04 00000000 00000003 00000004 # sllv
D 0040002c 00c74006 10 00 06 07 08 00 06 00000000 00000006 00000007 # srlv
D 00400030 012a5807 12 00 09 0a 0b 00 07 00000000 00000009 0000000a # srav
D 00400034 00ac6900 0d 00 00 0c 0d 04 00 00000000 00000000 0000000c # sll, rs field dropped
D 00400038 000e7fc2 0f 00 00 0e 0f 1f 02 00000000 00000000 0000000e # srl by 31
D 0040003c 00108843 11 00 00 10 11 01 03 00000000 00000000 00000010 # sra
D 00400040 0253a018 05 00 12 13 00 00 18 00000000 00000012 00000013 # mult, rd dropped
D 00400044 02b60019 06 00 15 16 00 00 19 00000000 00000015 00000016 # multu
D 00400048 02f8101a 07 00 17 18 00 00 1a 00000000 00000017 00000018 # div, rd dropped
D 0040004c 033a001b 08 00 19 1a 00 00 1b 00000000 00000019 0000001a # divu
D 00400050 0022d810 09 00 00 00 1b 00 10 00000000 00000000 00000000 # mfhi
D 00400054 0000e012 0a 00 00 00 1c 00 12 00000000 00000000 00000000 # mflo
D 00400058 03e32008 18 00 1f 00 00 00 08 00000000 0000001f 00000000 # jr
D 0040005c 03c0f809 17 00 1e 00 1f 00 09 00000000 0000001e 00000000 # jalr
D 00400060 70432002 19 1c 02 03 04 00 02 00000000 00000002 00000003 # mul
D 00400064 20228000 1a 08 01 02 02 00 00 ffff8000 00000001 00000002 # addi
D 00400068 24641234 1b 09 03 04 04 00 00 00001234 00000003 00000004 # addiu
D 0040006c 28a6ffff 1c 0a 05 06 06 00 00 ffffffff 00000005 00000006 # slti
D 00400070 2ce87fff 1d 0b 07 08 08 00 00 00007fff 00000007 00000008 # sltiu
D 00400074 352a00ff 1e 0d 09 0a 0a 00 00 000000ff 00000009 0000000a # ori
D 00400078 396ca5a5 1f 0e 0b 0c 0c 00 00 ffffa5a5 0000000b 0000000c # xori
D 0040007c 3dae8001 25 0f 00 0e 0e 00 00 ffff8001 00000000 0000000e # lui, rs dropped
D 00400080 8df0fffc 20 23 0f 10 10 00 00 fffffffc 0000000f 00000010 # lw
D 00400084 ae320010 21 2b 11 12 12 00 00 00000010 00000011 00000012 # sw
D 00400088 82748000 22 20 13 14 14 00 00 ffff8000 00000013 00000014 # lb
D 0040008c 92b60001 23 24 15 16 16 00 00 00000001 00000015 00000016 # lbu
D 00400090 a2f8fff0 24 28 17 18 18 00 00 fffffff0 00000017 00000018 # sb
D 00400094 133afffe 26 04 19 1a 1a 00 00 fffffffe 00000019 0000001a # beq
D 00400098 177c0004 27 05 1b 1c 1c 00 00 00000004 0000001b 0000001c # bne
D 0040009c 1fa08888 28 07 1d 00 00 00 00 ffff8888 0000001d 00000000 # bgtz
D 004000a0 1bc00100 29 06 1e 00 00 00 00 00000100 0000001e 00000000 # blez
D 004000a4 0480ff00 2a 01 04 00 00 00 00 ffffff00 00000004 00000000 # bltz
D 004000a8 04c10020 2b 01 06 01 00 00 00 00000020 00000006 00000001 # bgez
D 004000ac 04c20020 3f 00 00 00 00 00 00 00000000 00000000 00000000 # regimm rt=2, illegal
D 004000b0 0bffffff 2c 02 00 00 00 00 00 03ffffff 00000000 00000000 # j, top target bit set
D 004000b4 0c123456 2d 03 00 00 00 00 00 00123456 00000000 00000000 # jal
D 004000b8 00000000 00 00 00 00 00 00 00 00000000 00000000 00000000 # nop
D 004000bc fc210005 3f 00 00 00 00 00 00 00000000 00000000 00000000 # opcode 3f, illegal
D 004000c0 00221801 3f 00 00 00 00 00 00 00000000 00000000 00000000 # funct 01, illegal
D 004000c4 70221800 3f 00 00 00 00 00 00 00000000 00000000 00000000 # special op, funct 00
W 05 deadbeef
W 07 0000abcd
D 004000c8 00a71820 01 00 05 07 03 00 20 00000000 deadbeef 0000abcd # add reads new r5, r7
W 00 12345678
D 004000cc 000e7fc2 0f 00 00 0e 0f 1f 02 00000000 12345678 0000000e # srl reads written r0
D 004000d0 20228000 1a 08 01 02 02 00 00 ffff8000 00000001 00000002 # addi before stall
S 3
D 004000d4 0295b026 15 00 14 15 16 00 26 00000000 00000014 00000015 # xor after stall

// ==== files.f ====
+incdir+include
verilog/isa_pkg.sv
verilog/decode_pkg.sv
verilog/insn_decoder.sv
verilog/reg_file.sv
verilog/decode_stage.sv
dv/decode_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module decode_stage_tb -o decode_stage_tb

./obj_dir/decode_stage_tb | tee sim.log

if grep -qx "all tests passed" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi
